//--- source/bresenham_stepper.sv
`timescale 1ns/1ps

module bresenham_stepper (
  input  logic     clk,
  input  logic     rst,
  line_cmd_if.stepper cmd,
  pixel_if.source  pix
);
  import line_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_RUN
  } state_t;

  state_t state;

  // setup side, combinational
  logic signed [COORD_W:0] dx;
  logic signed [COORD_W:0] dy;
  coord_t abs_dx;
  coord_t abs_dy;
  logic   steep;
  coord_t sx0;
  coord_t sy0;
  coord_t sx1;
  coord_t sy1;
  coord_t major_span;
  coord_t minor_span;
  logic   minor_down;

  // walking state
  logic   steep_q;
  logic   minor_down_q;
  coord_t maj;
  coord_t mnr;
  coord_t maj_end;
  coord_t d_major;
  coord_t d_minor;
  logic signed [COORD_W+1:0] err;
  logic signed [COORD_W+1:0] err_sub;
  logic   last;

  always_comb begin
    dx = $signed({1'b0, cmd.x1}) - $signed({1'b0, cmd.x0});
    dy = $signed({1'b0, cmd.y1}) - $signed({1'b0, cmd.y0});
    abs_dx = dx[COORD_W] ? coord_t'(-dx) : coord_t'(dx);
    abs_dy = dy[COORD_W] ? coord_t'(-dy) : coord_t'(dy);
    steep = abs_dy > abs_dx;
    // steep lines walk along y, so trade axes
    sx0 = steep ? cmd.y0 : cmd.x0;
    sy0 = steep ? cmd.x0 : cmd.y0;
    sx1 = steep ? cmd.y1 : cmd.x1;
    sy1 = steep ? cmd.x1 : cmd.y1;
    // always walk toward increasing major
    if (sx0 > sx1) begin
      sx0 = steep ? cmd.y1 : cmd.x1;
      sy0 = steep ? cmd.x1 : cmd.y1;
      sx1 = steep ? cmd.y0 : cmd.x0;
      sy1 = steep ? cmd.x0 : cmd.y0;
    end
    major_span = sx1 - sx0;
    minor_down = sy1 < sy0;
    minor_span = minor_down ? sy0 - sy1 : sy1 - sy0;
  end

  // error after one major step
  assign err_sub = err - $signed({2'b00, d_minor});
  assign last = (maj == maj_end);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd.start) begin
            state <= ST_SETUP;
          end
        end
        ST_SETUP: begin
          state <= ST_RUN;
        end
        ST_RUN: begin
          // done once the end pixel is written
          if (pix.take && last) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_SETUP) begin
      steep_q <= steep;
      minor_down_q <= minor_down;
      maj <= sx0;
      mnr <= sy0;
      maj_end <= sx1;
      d_major <= major_span;
      d_minor <= minor_span;
      // error starts at half the major span
      err <= $signed({2'b00, major_span >> 1});
    end else if (state == ST_RUN && pix.take && !last) begin
      maj <= maj + 1'b1;
      if (err_sub < 0) begin
        // minor step, then add the span back
        mnr <= minor_down_q ? mnr - 1'b1 : mnr + 1'b1;
        err <= err_sub + $signed({2'b00, d_major});
      end else begin
        err <= err_sub;
      end
    end
  end

  assign cmd.busy = (state != ST_IDLE);
  assign pix.valid = (state == ST_RUN);
  // back to screen axes
  assign pix.x = steep_q ? mnr : maj;
  assign pix.y = steep_q ? maj : mnr;

  // pixel held until the packer takes it
  a_pix_stable: assert property (@(posedge clk) disable iff (rst)
    pix.valid && !pix.take |=> pix.valid && $stable(pix.x) && $stable(pix.y));

endmodule

//--- source/frame_write_packer.sv
`timescale 1ns/1ps

module frame_write_packer (
  input  logic                  clk,
  input  logic                  rst,
  pixel_if.sink                 pix,
  input  line_pkg::color_t      color,
  input  line_pkg::frame_sel_t  frame_sel,
  input  logic                  af_full,
  input  logic                  wdf_full,
  output line_pkg::mem_addr_t   af_addr_din,
  output logic                  af_wr_en,
  output line_pkg::beat_t       wdf_din,
  output logic                  wdf_wr_en,
  output line_pkg::byte_mask_t  wdf_mask_din
);
  import line_pkg::*;

  // slot of the pixel inside its burst
  logic [$clog2(PIX_PER_BURST)-1:0] slot;
  // second beat of the burst
  logic       beat2;
  // mask for the beat that holds the pixel
  byte_mask_t pix_mask;

  assign slot = pix.x[$clog2(PIX_PER_BURST)-1:0];

  // zeros, frame, row, burst column, two zero bits
  assign af_addr_din = {{(ADDR_W - FRAME_SEL_W - 2 * COORD_W + 1){1'b0}},
                        frame_sel,
                        pix.y,
                        pix.x[COORD_W-1:$clog2(PIX_PER_BURST)],
                        2'b00};

  // color padded to 32 bits in every lane
  assign wdf_din = {PIX_PER_BEAT{{(DATA_W / PIX_PER_BEAT - $bits(color_t)){1'b0}}, color}};

  always_comb begin
    pix_mask = MASK_ALL_OFF;
    // slot 0 sits in the top nibble
    pix_mask[{~slot[1:0], 2'b00} +: 4] = 4'h0;
  end

  // slots 0..3 in beat 1, 4..7 in beat 2
  assign wdf_mask_din = (beat2 == slot[2]) ? pix_mask : MASK_ALL_OFF;

  // beat 1 needs room in both fifos
  assign af_wr_en = pix.valid && !beat2 && !af_full && !wdf_full;
  // beat 2 only touches the data fifo
  assign wdf_wr_en = pix.valid && (beat2 ? !wdf_full : (!af_full && !wdf_full));
  assign pix.take = beat2 && wdf_wr_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      beat2 <= 1'b0;
    end else if (af_wr_en) begin
      beat2 <= 1'b1;
    end else if (pix.take) begin
      beat2 <= 1'b0;
    end
  end

  // stepper keeps the pixel up through its second beat
  a_pix_held_in_burst: assert property (@(posedge clk) disable iff (rst)
    beat2 |-> pix.valid);

endmodule

//--- source/line_cmd_if.sv
`timescale 1ns/1ps

interface line_cmd_if;
  import line_pkg::*;

  // endpoints in screen coordinates
  coord_t x0;
  coord_t y0;
  coord_t x1;
  coord_t y1;
  // one-cycle launch pulse
  logic start;
  // stepper working on a line
  logic busy;

  modport regs (output x0, y0, x1, y1, start, input busy);

  modport stepper (input x0, y0, x1, y1, start, output busy);

endinterface

//--- source/line_engine_top.sv
`timescale 1ns/1ps

module line_engine_top (
  input  logic                 clk,
  input  logic                 rst,
  // command side
  input  logic [31:0]          color_in,
  input  logic                 color_valid,
  input  logic                 point0_valid,
  input  logic                 point1_valid,
  input  logic                 trigger,
  input  logic [19:0]          point,
  input  logic [31:0]          frame_base,
  output logic                 ready,
  // memory controller fifos
  input  logic                 af_full,
  input  logic                 wdf_full,
  output line_pkg::mem_addr_t  af_addr_din,
  output logic                 af_wr_en,
  output line_pkg::beat_t      wdf_din,
  output logic                 wdf_wr_en,
  output line_pkg::byte_mask_t wdf_mask_din
);
  import line_pkg::*;

  // line-wide settings for the packer
  color_t     color;
  frame_sel_t frame_sel;

  line_cmd_if u_cmd_if ();
  pixel_if    u_pix_if ();

  line_setup_regs u_line_setup_regs (
    .clk          (clk),
    .rst          (rst),
    .color_in     (color_in),
    .color_valid  (color_valid),
    .point0_valid (point0_valid),
    .point1_valid (point1_valid),
    .trigger      (trigger),
    .point        (point),
    .frame_base   (frame_base),
    .ready        (ready),
    .cmd          (u_cmd_if.regs),
    .color        (color),
    .frame_sel    (frame_sel)
  );

  bresenham_stepper u_bresenham_stepper (
    .clk (clk),
    .rst (rst),
    .cmd (u_cmd_if.stepper),
    .pix (u_pix_if.source)
  );

  frame_write_packer u_frame_write_packer (
    .clk          (clk),
    .rst          (rst),
    .pix          (u_pix_if.sink),
    .color        (color),
    .frame_sel    (frame_sel),
    .af_full      (af_full),
    .wdf_full     (wdf_full),
    .af_addr_din  (af_addr_din),
    .af_wr_en     (af_wr_en),
    .wdf_din      (wdf_din),
    .wdf_wr_en    (wdf_wr_en),
    .wdf_mask_din (wdf_mask_din)
  );

endmodule

//--- source/line_pkg.sv
package line_pkg;

  // screen coordinates, 1024 x 1024 max
  localparam int COORD_W = 10;
  typedef logic [COORD_W-1:0] coord_t;

  // 8 bits each for r, g, b
  typedef logic [23:0] color_t;

  // address fifo word
  localparam int ADDR_W = 31;
  typedef logic [ADDR_W-1:0] mem_addr_t;

  // write data fifo beat
  localparam int DATA_W = 128;
  typedef logic [DATA_W-1:0] beat_t;

  // byte mask, active low
  // a zero bit lets its byte through
  localparam int MASK_W = 16;
  typedef logic [MASK_W-1:0] byte_mask_t;

  // 32-bit pixels, four per beat, two beats per burst
  localparam int PIX_PER_BEAT = 4;
  localparam int PIX_PER_BURST = 8;

  // frame selector taken from frame base bits 27:22
  localparam int FRAME_SEL_W = 6;
  localparam int FRAME_SEL_LSB = 22;
  typedef logic [FRAME_SEL_W-1:0] frame_sel_t;

  // beat that writes nothing
  localparam byte_mask_t MASK_ALL_OFF = '1;

endpackage

//--- source/line_setup_regs.sv
`timescale 1ns/1ps

module line_setup_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           color_in,
  input  logic                  color_valid,
  input  logic                  point0_valid,
  input  logic                  point1_valid,
  input  logic                  trigger,
  input  logic [19:0]           point,
  input  logic [31:0]           frame_base,
  output logic                  ready,
  line_cmd_if.regs              cmd,
  output line_pkg::color_t      color,
  output line_pkg::frame_sel_t  frame_sel
);
  import line_pkg::*;

  // shadow copies, loaded any time
  color_t color_hold;
  coord_t hold_x0;
  coord_t hold_y0;
  coord_t hold_x1;
  coord_t hold_y1;
  // set by the first color strobe
  logic   color_held;
  // trigger taken this cycle
  logic   accept;

  // low from the start pulse until the stepper lets go
  assign ready = !cmd.start && !cmd.busy;
  assign accept = trigger && ready && color_held;

  always_ff @(posedge clk) begin
    if (rst) begin
      color_held <= 1'b0;
      cmd.start <= 1'b0;
    end else begin
      if (color_valid) begin
        color_held <= 1'b1;
      end
      // start is high for exactly one cycle
      cmd.start <= accept;
    end
  end

  always_ff @(posedge clk) begin
    // only the rgb bytes are kept
    if (color_valid) begin
      color_hold <= color_in[23:0];
    end
    // upper ten bits x, lower ten bits y
    if (point0_valid) begin
      hold_x0 <= point[19:10];
      hold_y0 <= point[9:0];
    end
    if (point1_valid) begin
      hold_x1 <= point[19:10];
      hold_y1 <= point[9:0];
    end
    // freeze the command for the whole line
    if (accept) begin
      cmd.x0 <= hold_x0;
      cmd.y0 <= hold_y0;
      cmd.x1 <= hold_x1;
      cmd.y1 <= hold_y1;
      color <= color_hold;
      frame_sel <= frame_base[FRAME_SEL_LSB +: FRAME_SEL_W];
    end
  end

  // no new launch while the stepper still holds a line
  a_start_not_busy: assert property (@(posedge clk) disable iff (rst)
    cmd.start |-> !cmd.busy);

endmodule

//--- source/pixel_if.sv
`timescale 1ns/1ps

interface pixel_if;
  import line_pkg::*;

  // screen position of the current pixel
  coord_t x;
  coord_t y;
  // level, holds x and y until take
  logic valid;
  // pulse when the pixel's last beat is written
  logic take;

  modport source (output x, y, valid, input take);

  modport sink (input x, y, valid, output take);

endinterface

//--- verif/line_engine_tb.sv
`timescale 1ns/1ps

module line_engine_tb;
  import line_pkg::*;

  localparam int N_ROWS = 9;

  logic        clk;
  logic        rst;
  logic [31:0] color_in;
  logic        color_valid;
  logic        point0_valid;
  logic        point1_valid;
  logic        trigger;
  logic [19:0] point;
  logic [31:0] frame_base;
  logic        ready;
  logic        af_full;
  logic        wdf_full;
  mem_addr_t   af_addr_din;
  logic        af_wr_en;
  beat_t       wdf_din;
  logic        wdf_wr_en;
  byte_mask_t  wdf_mask_din;

  // stimulus table with one line per row
  string       row_name [N_ROWS];
  int          row_x0 [N_ROWS];
  int          row_y0 [N_ROWS];
  int          row_x1 [N_ROWS];
  int          row_y1 [N_ROWS];
  logic [31:0] row_color [N_ROWS];
  logic [31:0] row_base [N_ROWS];
  bit          row_stall [N_ROWS];

  // reference pixels of the line in flight in screen coordinates
  int         exp_x [$];
  int         exp_y [$];
  color_t     exp_color;
  frame_sel_t exp_sel;

  int    cycle = 0;
  int    limit = 0;
  int    trig_edge = 0;
  int    last_beat_edge = 0;
  bit    in_flight = 0;
  bit    check_ready = 0;
  bit    cur_stall = 0;
  bit    second_beat = 0;
  bit    first_burst = 0;
  int    errors = 0;
  int    row_errs = 0;
  string cur_name = "reset";

  line_engine_top u_line_engine_top (
    .clk          (clk),
    .rst          (rst),
    .color_in     (color_in),
    .color_valid  (color_valid),
    .point0_valid (point0_valid),
    .point1_valid (point1_valid),
    .trigger      (trigger),
    .point        (point),
    .frame_base   (frame_base),
    .ready        (ready),
    .af_full      (af_full),
    .wdf_full     (wdf_full),
    .af_addr_din  (af_addr_din),
    .af_wr_en     (af_wr_en),
    .wdf_din      (wdf_din),
    .wdf_wr_en    (wdf_wr_en),
    .wdf_mask_din (wdf_mask_din)
  );

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  // number of rising edges so far
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  always @(posedge clk) begin
    if (limit > 0 && cycle >= limit) begin
      $display("run stopped after %0d cycles, line %s never finished", cycle, cur_name);
      $display("tests failed");
      $finish;
    end
  end

  function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
  endfunction

  // zeros, frame selector, row, burst column, two zero bits
  function automatic mem_addr_t addr_of(input int x, input int y, input frame_sel_t sel);
    mem_addr_t a;
    a = (mem_addr_t'(sel) << 19) | (mem_addr_t'(y) << 9) | (mem_addr_t'(x / 8) << 2);
    return a;
  endfunction

  // color zero padded to 32 bits in four lanes
  function automatic beat_t data_of(input color_t c);
    return {4{8'h00, c}};
  endfunction

  // active low mask with slot 0 in the top nibble of beat 0
  function automatic byte_mask_t mask_of(input int x, input int beat);
    int         slot;
    byte_mask_t m;
    slot = x % 8;
    m = 16'hffff;
    if (slot / 4 == beat) begin
      m[(3 - slot % 4) * 4 +: 4] = 4'h0;
    end
    return m;
  endfunction

  task automatic set_row(input int r, input string name, input int x0, input int y0,
                         input int x1, input int y1, input logic [31:0] color,
                         input logic [31:0] base, input bit stall);
    row_name[r] = name;
    row_x0[r] = x0;
    row_y0[r] = y0;
    row_x1[r] = x1;
    row_y1[r] = y1;
    row_color[r] = color;
    row_base[r] = base;
    row_stall[r] = stall;
  endtask

  // walk the line along its major axis and step minor on error underflow
  task automatic build_expected(input int x0, input int y0, input int x1, input int y1);
    int a0;
    int b0;
    int a1;
    int b1;
    int t;
    int a;
    int b;
    int dmaj;
    int dmin;
    int step;
    int err;
    bit steep;
    exp_x.delete();
    exp_y.delete();
    steep = abs_int(y1 - y0) > abs_int(x1 - x0);
    a0 = steep ? y0 : x0;
    b0 = steep ? x0 : y0;
    a1 = steep ? y1 : x1;
    b1 = steep ? x1 : y1;
    if (a0 > a1) begin
      t = a0;
      a0 = a1;
      a1 = t;
      t = b0;
      b0 = b1;
      b1 = t;
    end
    dmaj = a1 - a0;
    dmin = abs_int(b1 - b0);
    step = (b1 < b0) ? -1 : 1;
    err = dmaj / 2;
    b = b0;
    for (a = a0; a <= a1; a++) begin
      // back to screen axes
      exp_x.push_back(steep ? b : a);
      exp_y.push_back(steep ? a : b);
      err -= dmin;
      if (err < 0) begin
        b += step;
        err += dmaj;
      end
    end
  endtask

  task automatic fail_value(input string what, input logic [127:0] expected,
                            input logic [127:0] actual);
    $display("** Error %s: %s expected %0h actual %0h", cur_name, what, expected, actual);
    errors++;
    row_errs++;
  endtask

  task automatic fail_plain(input string what);
    $display("** Error %s: %s", cur_name, what);
    errors++;
    row_errs++;
  endtask

  // full levels are random only on stall rows
  initial begin
    int rnd;
    af_full = 1'b0;
    wdf_full = 1'b0;
    rnd = $urandom(32'hd0fd);
    forever begin
      @(posedge clk);
      #1;
      if (cur_stall) begin
        af_full = ($urandom % 4) == 0;
        wdf_full = ($urandom % 4) == 0;
      end else begin
        af_full = 1'b0;
        wdf_full = 1'b0;
      end
    end
  end

  // fifo side sampled mid cycle
  // a write seen here is taken at edge cycle + 1
  always @(negedge clk) begin
    if (!rst) begin
      if (af_wr_en && af_full) begin
        fail_plain("address write while the address fifo is full");
      end
      if (wdf_wr_en && wdf_full) begin
        fail_plain("data write while the data fifo is full");
      end
      // ready low for the whole line and high right after it
      if (check_ready) begin
        if (!ready) begin
          fail_value("ready after last beat", 1, ready);
        end
        check_ready = 1'b0;
      end else if (in_flight && cycle >= trig_edge && ready) begin
        fail_value("ready during line", 0, ready);
      end
      if (!second_beat) begin
        if (af_wr_en) begin
          if (exp_x.size() == 0) begin
            fail_plain("burst written with no pixel left to draw");
          end else begin
            if (!wdf_wr_en) begin
              fail_plain("address written without its first data beat");
            end
            if (af_addr_din !== addr_of(exp_x[0], exp_y[0], exp_sel)) begin
              fail_value("address", addr_of(exp_x[0], exp_y[0], exp_sel), af_addr_din);
            end
            if (wdf_din !== data_of(exp_color)) begin
              fail_value("beat 1 data", data_of(exp_color), wdf_din);
            end
            if (wdf_mask_din !== mask_of(exp_x[0], 0)) begin
              fail_value("beat 1 mask", mask_of(exp_x[0], 0), wdf_mask_din);
            end
            // latency and pixel rate only hold without back-pressure
            if (!cur_stall && first_burst && cycle + 1 != trig_edge + 3) begin
              fail_value("first burst edge", trig_edge + 3, cycle + 1);
            end
            if (!cur_stall && !first_burst && cycle + 1 != last_beat_edge + 2) begin
              fail_value("burst edge", last_beat_edge + 2, cycle + 1);
            end
            first_burst = 1'b0;
            last_beat_edge = cycle + 1;
            second_beat = 1'b1;
          end
        end else if (wdf_wr_en) begin
          fail_plain("data beat written without an address");
        end
      end else begin
        if (af_wr_en) begin
          fail_plain("address written in the middle of a burst");
        end
        if (wdf_wr_en) begin
          if (wdf_din !== data_of(exp_color)) begin
            fail_value("beat 2 data", data_of(exp_color), wdf_din);
          end
          if (wdf_mask_din !== mask_of(exp_x[0], 1)) begin
            fail_value("beat 2 mask", mask_of(exp_x[0], 1), wdf_mask_din);
          end
          if (!cur_stall && cycle + 1 != last_beat_edge + 1) begin
            fail_value("beat 2 edge", last_beat_edge + 1, cycle + 1);
          end
          exp_x.pop_front();
          exp_y.pop_front();
          second_beat = 1'b0;
          if (exp_x.size() == 0) begin
            in_flight = 1'b0;
            check_ready = 1'b1;
          end
        end
      end
    end
  end

  initial begin
    int r;
    int npix;
    int n_pass;
    rst = 1'b1;
    color_in = '0;
    color_valid = 1'b0;
    point0_valid = 1'b0;
    point1_valid = 1'b0;
    trigger = 1'b0;
    point = '0;
    frame_base = '0;
    n_pass = 0;

    set_row(0, "horizontal", 3, 5, 17, 5, 32'h0011_2233, 32'h0040_0000, 0);
    set_row(1, "shallow", 0, 0, 12, 5, 32'h00a0_b0c0, 32'h0040_0000, 0);
    set_row(2, "shallow_rtl", 40, 20, 10, 9, 32'h00ff_8000, 32'h0080_0000, 0);
    set_row(3, "steep", 5, 2, 9, 20, 32'h0000_ff00, 32'h0080_0000, 0);
    set_row(4, "steep_up", 30, 40, 27, 10, 32'h0000_00ff, 32'h00c0_0000, 0);
    set_row(5, "single_point", 7, 7, 7, 7, 32'h0012_3456, 32'h00c0_0000, 0);
    set_row(6, "stall_shallow_rtl", 40, 20, 10, 9, 32'h00ff_8000, 32'h0080_0000, 1);
    set_row(7, "stall_steep_up", 30, 40, 27, 10, 32'h0000_00ff, 32'h00c0_0000, 1);
    // upper color byte and stray base bits must not show
    set_row(8, "frame_change", 1000, 1000, 1023, 1010, 32'hdeab_cdef, 32'hfbc1_2345, 0);

    // 8 cycles per pixel plus 20 per line
    for (r = 0; r < N_ROWS; r++) begin
      npix = abs_int(row_x1[r] - row_x0[r]);
      if (abs_int(row_y1[r] - row_y0[r]) > npix) begin
        npix = abs_int(row_y1[r] - row_y0[r]);
      end
      limit += 8 * (npix + 1) + 20;
    end

    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    for (r = 0; r < N_ROWS; r++) begin
      cur_name = row_name[r];
      row_errs = 0;
      build_expected(row_x0[r], row_y0[r], row_x1[r], row_y1[r]);
      npix = exp_x.size();
      exp_color = row_color[r][23:0];
      exp_sel = row_base[r][27:22];
      cur_stall = row_stall[r];
      first_burst = 1'b1;

      // color then both points then trigger
      @(posedge clk);
      #1;
      color_in = row_color[r];
      frame_base = row_base[r];
      color_valid = 1'b1;
      @(posedge clk);
      #1;
      color_valid = 1'b0;
      point = {10'(row_x0[r]), 10'(row_y0[r])};
      point0_valid = 1'b1;
      @(posedge clk);
      #1;
      point0_valid = 1'b0;
      point = {10'(row_x1[r]), 10'(row_y1[r])};
      point1_valid = 1'b1;
      @(posedge clk);
      #1;
      point1_valid = 1'b0;
      if (!ready) begin
        fail_plain("engine not ready for a new line");
      end
      trigger = 1'b1;
      trig_edge = cycle + 1;
      in_flight = 1'b1;
      @(posedge clk);
      #1;
      trigger = 1'b0;
      // new color and base during the line belong to the next line only
      color_in = ~row_color[r];
      frame_base = ~row_base[r];
      color_valid = 1'b1;
      @(posedge clk);
      #1;
      color_valid = 1'b0;

      // monitor clears these once the last pixel and ready are seen
      while (in_flight || check_ready) begin
        @(posedge clk);
      end
      cur_stall = 1'b0;
      if (row_errs == 0) begin
        n_pass++;
        $display("test %s: ok, %0d pixels", cur_name, npix);
      end else begin
        $display("test %s: %0d mismatches over %0d pixels", cur_name, row_errs, npix);
      end
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors", N_ROWS, n_pass,
             N_ROWS - n_pass, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
source/line_pkg.sv
source/line_cmd_if.sv
source/pixel_if.sv
source/line_setup_regs.sv
source/bresenham_stepper.sv
source/frame_write_packer.sv
source/line_engine_top.sv
verif/line_engine_tb.sv
